// ==== hdl/arcade_config.svh ====
/*
 * Arcade control configuration
 * Widths, counts and PS/2 set 2 key codes shared by the control blocks
 */
`ifndef ARCADE_CONFIG_SVH
`define ARCADE_CONFIG_SVH

// Widths and counts
`define SCAN_SW_W        12
`define HELD_KEYS        8
`define RESET_DELAY      256
`define PS2_IDLE_CYCLES  4096

// ------------------------------
// Key codes, PS/2 set 2 make bytes
// ------------------------------
// Arrows arrive behind an E0 prefix
`define KEY_UP      8'h75
`define KEY_DOWN    8'h72
`define KEY_LEFT    8'h6B
`define KEY_RIGHT   8'h74
`define KEY_CTRL    8'h14
`define KEY_ALT     8'h11
`define KEY_START1  8'h16
`define KEY_START2  8'h1E
`define KEY_F1      8'h05
`define KEY_F2      8'h06
`define KEY_F3      8'h04
`define KEY_F4      8'h0C
`define KEY_F12     8'h07
`define KEY_BKSP    8'h66

`endif

// ==== hdl/input_pkg.sv ====
/*
 * Input data types
 * Keyboard bytes, held keys, switch vector and joystick connector samples
 */
`include "arcade_config.svh"

package input_pkg;

  // One byte as received from the keyboard
  typedef logic [7:0] scan_code_t;

  // Bits 0-5 directions and fire in connector order, 6-7 start keys
  typedef logic [`HELD_KEYS-1:0] held_keys_t;

  // Held keys low, F1-F4 option toggles above them
  typedef logic [`SCAN_SW_W-1:0] scan_sw_t;

  // Raw connector sample, active low
  typedef logic [7:0] joy_vec_t;

endpackage

// ==== hdl/ctrl_pkg.sv ====
/*
 * Control types
 * Reset delay counter and PS/2 frame receiver states
 */
`include "arcade_config.svh"

package ctrl_pkg;

  // Sized so that its last value ends the power-on delay
  typedef logic [$clog2(`RESET_DELAY)-1:0] delay_cnt_t;

  // Frame receiver FSM
  typedef enum logic [1:0] {
    rx_idle,
    rx_shift,
    rx_done
  } rx_state_t;

endpackage

// ==== hdl/key_event_if.sv ====
/*
 * Key event interface
 * One decoded keyboard event per strobe, no back-pressure
 */
interface key_event_if;

  input_pkg::scan_code_t code;
  logic                  extended;
  // Break event, byte was preceded by F0
  logic                  released;
  // Payload valid only while strobe is high
  logic                  strobe;

  modport src (output code, output extended, output released, output strobe);
  modport dst (input code, input extended, input released, input strobe);

endinterface

// ==== hdl/ps2_receiver.sv ====
/*
 * PS/2 frame receiver
 * Synchronizes the keyboard lines, shifts in 11-bit frames on falling
 * clock edges, checks start, odd parity and stop, and folds the E0 and
 * F0 prefixes into the flags of the following event
 */
`include "arcade_config.svh"

module ps2_receiver (
  input  logic     pclk,
  input  logic     pll_lckd,
  input  logic     ps2_clk,
  input  logic     ps2_data,
  key_event_if.src ev
);

  localparam int IDLE_W = $clog2(`PS2_IDLE_CYCLES);
  localparam input_pkg::scan_code_t EXT_PREFIX = 8'hE0;
  localparam input_pkg::scan_code_t BRK_PREFIX = 8'hF0;

  logic [1:0]            clk_sync;
  logic [1:0]            data_sync;
  logic                  clk_prev;
  logic                  fall;
  ctrl_pkg::rx_state_t   state;
  logic [3:0]            bit_cnt;
  logic [9:0]            frame;
  logic [IDLE_W-1:0]     idle_cnt;
  logic                  ext_pend;
  logic                  rel_pend;
  logic                  stop_edge;
  logic                  frame_ok;
  input_pkg::scan_code_t rx_byte;

  // ------------------------------
  // Line synchronizers
  // ------------------------------
  always_ff @(posedge pclk or negedge pll_lckd) begin
    if (!pll_lckd) begin
      clk_sync  <= 2'b11;
      data_sync <= 2'b11;
      clk_prev  <= 1'b1;
    end else begin
      clk_sync  <= {clk_sync[0], ps2_clk};
      data_sync <= {data_sync[0], ps2_data};
      clk_prev  <= clk_sync[1];
    end
  end

  assign fall = clk_prev & ~clk_sync[1];

  // Frame holds start..parity once the stop bit is on the line
  assign rx_byte   = frame[8:1];
  assign stop_edge = (state == ctrl_pkg::rx_shift) && fall && (bit_cnt == 4'd10);
  assign frame_ok  = ~frame[0] & (^{rx_byte, frame[9]}) & data_sync[1];

  always_ff @(posedge pclk) begin
    if (fall) begin
      frame <= {data_sync[1], frame[9:1]};
    end
  end

  // Event payload, sampled with the stop bit
  always_ff @(posedge pclk) begin
    if (stop_edge) begin
      ev.code     <= rx_byte;
      ev.extended <= ext_pend;
      ev.released <= rel_pend;
    end
  end

  // ------------------------------
  // Frame FSM
  // ------------------------------
  always_ff @(posedge pclk or negedge pll_lckd) begin
    if (!pll_lckd) begin
      state     <= ctrl_pkg::rx_idle;
      bit_cnt   <= '0;
      idle_cnt  <= '0;
      ext_pend  <= 1'b0;
      rel_pend  <= 1'b0;
      ev.strobe <= 1'b0;
    end else begin
      ev.strobe <= 1'b0;
      case (state)
        ctrl_pkg::rx_idle: begin
          idle_cnt <= '0;
          bit_cnt  <= '0;
          // First falling edge carries the start bit
          if (fall) begin
            bit_cnt <= 4'd1;
            state   <= ctrl_pkg::rx_shift;
          end
        end
        ctrl_pkg::rx_shift: begin
          if (fall) begin
            idle_cnt <= '0;
            bit_cnt  <= bit_cnt + 4'd1;
            if (bit_cnt == 4'd10) begin
              state <= ctrl_pkg::rx_done;
              if (frame_ok) begin
                if (rx_byte == EXT_PREFIX) begin
                  ext_pend <= 1'b1;
                end else if (rx_byte == BRK_PREFIX) begin
                  rel_pend <= 1'b1;
                end else begin
                  ev.strobe <= 1'b1;
                end
              end
            end
          end else if (idle_cnt == IDLE_W'(`PS2_IDLE_CYCLES - 1)) begin
            // Keyboard went quiet mid-frame
            state <= ctrl_pkg::rx_idle;
          end else begin
            idle_cnt <= idle_cnt + 1'b1;
          end
        end
        ctrl_pkg::rx_done: begin
          // Prefixes are consumed by the event just sent
          if (ev.strobe) begin
            ext_pend <= 1'b0;
            rel_pend <= 1'b0;
          end
          state <= ctrl_pkg::rx_idle;
        end
        default: state <= ctrl_pkg::rx_idle;
      endcase
    end
  end

endmodule

// ==== hdl/key_mapper.sv ====
/*
 * Key mapper
 * Keeps held game keys and F1-F4 option toggles from key events,
 * and raises the reset key level and the master reset pulse
 */
`include "arcade_config.svh"

module key_mapper (
  input  logic                    pclk,
  input  logic                    pll_lckd,
  key_event_if.dst                ev,
  output input_pkg::held_keys_t   held,
  output input_pkg::scan_sw_t     scan_sw,
  output logic                    reset_key,
  output logic                    master_reset
);

  localparam int OPT_W    = `SCAN_SW_W - `HELD_KEYS;
  localparam int CTRL_BIT = 4;
  localparam int ALT_BIT  = 5;

  logic                  make;
  input_pkg::held_keys_t key_hit;
  logic [OPT_W-1:0]      opt_hit;
  logic [OPT_W-1:0]      opt;
  logic                  f12_hit;
  logic                  bksp_hit;

  assign make    = ~ev.released;
  assign scan_sw = {opt, held};

  // ------------------------------
  // Code decode
  // ------------------------------
  always_comb begin
    key_hit  = '0;
    opt_hit  = '0;
    f12_hit  = 1'b0;
    bksp_hit = 1'b0;
    case (ev.code)
      // Arrows only count behind E0, the bare codes are keypad keys
      `KEY_UP:     key_hit[0] = ev.extended;
      `KEY_DOWN:   key_hit[1] = ev.extended;
      `KEY_LEFT:   key_hit[2] = ev.extended;
      `KEY_RIGHT:  key_hit[3] = ev.extended;
      `KEY_CTRL:   key_hit[CTRL_BIT] = 1'b1;
      `KEY_ALT:    key_hit[ALT_BIT] = 1'b1;
      `KEY_START1: key_hit[6] = 1'b1;
      `KEY_START2: key_hit[7] = 1'b1;
      `KEY_F1:     opt_hit[0] = 1'b1;
      `KEY_F2:     opt_hit[1] = 1'b1;
      `KEY_F3:     opt_hit[2] = 1'b1;
      `KEY_F4:     opt_hit[3] = 1'b1;
      `KEY_F12:    f12_hit = 1'b1;
      `KEY_BKSP:   bksp_hit = 1'b1;
      default: ;
    endcase
  end

  // ------------------------------
  // Key state
  // ------------------------------
  always_ff @(posedge pclk or negedge pll_lckd) begin
    if (!pll_lckd) begin
      held         <= '0;
      opt          <= '0;
      reset_key    <= 1'b0;
      master_reset <= 1'b0;
    end else begin
      master_reset <= 1'b0;
      if (ev.strobe) begin
        if (make) begin
          held <= held | key_hit;
          // Options flip on make only
          opt  <= opt ^ opt_hit;
        end else begin
          held <= held & ~key_hit;
        end
        if (f12_hit) begin
          reset_key <= make;
        end
        // Ctrl+Alt+Backspace
        if (bksp_hit && make && held[CTRL_BIT] && held[ALT_BIT]) begin
          master_reset <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== hdl/joy_splitter.sv ====
/*
 * Joystick splitter
 * Time-multiplexes the shared connector between two players and merges
 * the board joystick and held keyboard keys into player A
 */
module joy_splitter (
  input  logic                  pclk,
  input  logic                  pll_lckd,
  input  logic [5:0]            joystick,
  input  input_pkg::joy_vec_t   jjoy,
  input  input_pkg::held_keys_t held,
  output logic                  joy_select,
  output logic [5:0]            joy_a,
  output logic [5:0]            joy_b,
  output logic [1:0]            player
);

  input_pkg::joy_vec_t cap_a;
  input_pkg::joy_vec_t cap_b;
  input_pkg::joy_vec_t a_in;

  // Start key lands on connector bit 7, bit 6 is unused
  assign a_in = jjoy & {2'b11, joystick} & ~{held[6], 1'b0, held[5:0]};

  always_ff @(posedge pclk or negedge pll_lckd) begin
    if (!pll_lckd) begin
      joy_select <= 1'b0;
      cap_a      <= '1;
      cap_b      <= '1;
    end else begin
      joy_select <= ~joy_select;
      // Connector shows player A while select is low
      if (!joy_select) begin
        cap_a <= a_in;
      end else begin
        cap_b <= jjoy;
      end
    end
  end

  assign joy_a  = cap_a[5:0];
  assign joy_b  = cap_b[5:0];
  assign player = {cap_b[7], cap_a[7]};

endmodule

// ==== hdl/reset_sequencer.sv ====
/*
 * Reset sequencer
 * Holds the core in reset for a fixed delay after clock lock, merges
 * the keyboard and test resets, and registers the reboot request
 */
module reset_sequencer (
  input  logic pclk,
  input  logic pll_lckd,
  input  logic reset_key,
  input  logic master_reset,
  input  logic test_n,
  input  logic service_n,
  output logic core_reset,
  output logic reboot
);

  ctrl_pkg::delay_cnt_t delay_cnt;
  logic                 por_active;

  // Power-on part ends when the counter reaches its last value
  assign por_active = (delay_cnt != '1);

  // ------------------------------
  // Power-on delay
  // ------------------------------
  always_ff @(posedge pclk or negedge pll_lckd) begin
    if (!pll_lckd) begin
      delay_cnt <= '0;
    end else if (por_active) begin
      delay_cnt <= delay_cnt + 1'b1;
    end
  end

  // ------------------------------
  // Reset and reboot outputs
  // ------------------------------
  always_ff @(posedge pclk or negedge pll_lckd) begin
    if (!pll_lckd) begin
      core_reset <= 1'b1;
      reboot     <= 1'b0;
    end else begin
      core_reset <= por_active | reset_key | ~test_n;
      reboot     <= master_reset | ~service_n;
    end
  end

endmodule

// ==== hdl/arcade_ctrl_top.sv ====
/*
 * Arcade control subsystem top level
 * Keyboard decode, key mapping, joystick multiplexing and reset control
 */
module arcade_ctrl_top (
  input  logic                pclk,
  input  logic                pll_lckd,
  input  logic                ps2_clk,
  input  logic                ps2_data,
  input  logic [5:0]          joystick,
  input  input_pkg::joy_vec_t jjoy,
  input  logic                test_n,
  input  logic                service_n,
  output logic                joy_select,
  output logic [5:0]          joy_a,
  output logic [5:0]          joy_b,
  output logic [1:0]          player,
  output input_pkg::scan_sw_t scan_sw,
  output logic                led,
  output logic                core_reset,
  output logic                reboot
);

  input_pkg::held_keys_t held;
  logic                  reset_key;
  logic                  master_reset;

  key_event_if key_ev ();

  // ------------------------------
  // Keyboard path
  // ------------------------------
  ps2_receiver ps2_receiver_inst (
    .pclk     (pclk),
    .pll_lckd (pll_lckd),
    .ps2_clk  (ps2_clk),
    .ps2_data (ps2_data),
    .ev       (key_ev.src)
  );

  key_mapper key_mapper_inst (
    .pclk         (pclk),
    .pll_lckd     (pll_lckd),
    .ev           (key_ev.dst),
    .held         (held),
    .scan_sw      (scan_sw),
    .reset_key    (reset_key),
    .master_reset (master_reset)
  );

  // ------------------------------
  // Joystick and reset
  // ------------------------------
  joy_splitter joy_splitter_inst (
    .pclk       (pclk),
    .pll_lckd   (pll_lckd),
    .joystick   (joystick),
    .jjoy       (jjoy),
    .held       (held),
    .joy_select (joy_select),
    .joy_a      (joy_a),
    .joy_b      (joy_b),
    .player     (player)
  );

  reset_sequencer reset_sequencer_inst (
    .pclk         (pclk),
    .pll_lckd     (pll_lckd),
    .reset_key    (reset_key),
    .master_reset (master_reset),
    .test_n       (test_n),
    .service_n    (service_n),
    .core_reset   (core_reset),
    .reboot       (reboot)
  );

  // F2 option shown on the board LED
  assign led = scan_sw[9];

endmodule

// ==== tests/arcade_ctrl_assert.sv ====
/*
 * Joystick select and reset assertions
 * Bound into the joystick splitter and the reset sequencer
 */
module arcade_ctrl_assert #(
  parameter bit JOY_SIDE = 1'b0
) (
  input logic pclk,
  input logic pll_lckd,
  input logic joy_select,
  input logic reset_key,
  input logic master_reset,
  input logic test_n,
  input logic service_n,
  input logic core_reset,
  input logic reboot
);
  timeunit 1ns;
  timeprecision 1ps;

  int fails;

  initial fails = 0;

  if (JOY_SIDE) begin : g_joy
    // Select alternates every cycle
    select_rise: assert property (@(posedge pclk) disable iff (!pll_lckd)
      !joy_select |=> joy_select)
      else begin
        $error("joy_select stayed low for two cycles");
        fails++;
      end
    select_fall: assert property (@(posedge pclk) disable iff (!pll_lckd)
      joy_select |=> !joy_select)
      else begin
        $error("joy_select stayed high for two cycles");
        fails++;
      end
  end else begin : g_rst
    reset_held: assert property (@(posedge pclk) !pll_lckd |=> core_reset)
      else begin
        $error("core_reset low while the clock was unlocked");
        fails++;
      end
    // Key and test resets act one cycle later
    reset_request: assert property (@(posedge pclk) disable iff (!pll_lckd)
      (reset_key || !test_n) |=> core_reset)
      else begin
        $error("core_reset did not follow a reset request");
        fails++;
      end
    reboot_request: assert property (@(posedge pclk) disable iff (!pll_lckd)
      (master_reset || !service_n) |=> reboot)
      else begin
        $error("reboot did not follow a reboot request");
        fails++;
      end
    reboot_quiet: assert property (@(posedge pclk) disable iff (!pll_lckd)
      (!master_reset && service_n) |=> !reboot)
      else begin
        $error("reboot raised without a request");
        fails++;
      end
  end

endmodule

bind joy_splitter arcade_ctrl_assert #(.JOY_SIDE(1'b1)) joy_assert_inst (
  .pclk         (pclk),
  .pll_lckd     (pll_lckd),
  .joy_select   (joy_select),
  .reset_key    (1'b0),
  .master_reset (1'b0),
  .test_n       (1'b1),
  .service_n    (1'b1),
  .core_reset   (1'b1),
  .reboot       (1'b0)
);

bind reset_sequencer arcade_ctrl_assert #(.JOY_SIDE(1'b0)) reset_assert_inst (
  .pclk         (pclk),
  .pll_lckd     (pll_lckd),
  .joy_select   (1'b0),
  .reset_key    (reset_key),
  .master_reset (master_reset),
  .test_n       (test_n),
  .service_n    (service_n),
  .core_reset   (core_reset),
  .reboot       (reboot)
);

// ==== tests/arcade_ctrl_checker.sv ====
/*
 * Arcade control checker
 * Decodes the PS/2 pins, models keys, joystick capture and reset,
 * and compares every DUT output on each falling clock edge
 */
`include "arcade_config.svh"

module arcade_ctrl_checker (
  input  logic                pclk,
  input  logic                pll_lckd,
  input  logic                ps2_clk,
  input  logic                ps2_data,
  input  logic [5:0]          joystick,
  input  input_pkg::joy_vec_t jjoy,
  input  logic                test_n,
  input  logic                service_n,
  input  logic                joy_select,
  input  logic [5:0]          joy_a,
  input  logic [5:0]          joy_b,
  input  logic [1:0]          player,
  input  input_pkg::scan_sw_t scan_sw,
  input  logic                led,
  input  logic                core_reset,
  input  logic                reboot,
  output int                  errors,
  output int                  checks
);
  timeunit 1ns;
  timeprecision 1ps;

  logic       armed;
  logic       clk_q;
  logic [3:0] nbits;
  logic [9:0] shift;
  logic       ext_p;
  logic       rel_p;
  // Event delay line, {extended, release, code}
  logic [2:0] ev_v;
  logic [9:0] ev_d [3];
  logic [7:0] held_m;
  logic [3:0] opt_m;
  logic       rst_key_m;
  logic       mr_m;
  logic       sel_m;
  logic [7:0] cap_a_m;
  logic [7:0] cap_b_m;
  logic       core_m;
  logic       reboot_m;
  int         lock_cnt;

  function automatic int held_bit_of(input logic [7:0] code, input logic ext);
    case (code)
      `KEY_UP:     return ext ? 0 : -1;
      `KEY_DOWN:   return ext ? 1 : -1;
      `KEY_LEFT:   return ext ? 2 : -1;
      `KEY_RIGHT:  return ext ? 3 : -1;
      `KEY_CTRL:   return 4;
      `KEY_ALT:    return 5;
      `KEY_START1: return 6;
      `KEY_START2: return 7;
      default:     return -1;
    endcase
  endfunction

  function automatic int option_bit_of(input logic [7:0] code);
    case (code)
      `KEY_F1: return 0;
      `KEY_F2: return 1;
      `KEY_F3: return 2;
      `KEY_F4: return 3;
      default: return -1;
    endcase
  endfunction

  // Held keys pull player A low, start1 sits on connector bit 7
  function automatic logic [7:0] merge_player_a(input logic [7:0] conn,
                                                input logic [5:0] board,
                                                input logic [7:0] keys);
    logic [7:0] v;
    v = conn;
    for (int i = 0; i < 6; i++) begin
      v[i] = conn[i] & board[i] & ~keys[i];
    end
    v[7] = conn[7] & ~keys[6];
    return v;
  endfunction

  task automatic compare_value(input string name, input logic [15:0] exp,
                               input logic [15:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("error: %s expected 0x%0h actual 0x%0h at %0t", name, exp, act, $time);
    end
  endtask

  initial begin
    errors = 0;
    checks = 0;
    armed  = 1'b0;
  end

  always @(posedge pclk) armed <= 1'b1;

  // ------------------------------
  // PS/2 frame decode
  // ------------------------------
  always @(posedge pclk or negedge pll_lckd) begin
    if (!pll_lckd) begin
      clk_q <= 1'b1;
      nbits <= '0;
      ext_p <= 1'b0;
      rel_p <= 1'b0;
      ev_v  <= '0;
    end else begin
      clk_q   <= ps2_clk;
      ev_v    <= {ev_v[1:0], 1'b0};
      ev_d[1] <= ev_d[0];
      ev_d[2] <= ev_d[1];
      if (clk_q && !ps2_clk) begin
        if (nbits == 4'd10) begin
          nbits <= '0;
          // Start low, odd parity, stop high
          if (!shift[0] && (^shift[9:1]) && ps2_data) begin
            if (shift[8:1] == 8'hE0) begin
              ext_p <= 1'b1;
            end else if (shift[8:1] == 8'hF0) begin
              rel_p <= 1'b1;
            end else begin
              ev_v[0] <= 1'b1;
              ev_d[0] <= {ext_p, rel_p, shift[8:1]};
              ext_p   <= 1'b0;
              rel_p   <= 1'b0;
            end
          end
        end else begin
          shift <= {ps2_data, shift[9:1]};
          nbits <= nbits + 4'd1;
        end
      end
    end
  end

  // ------------------------------
  // Key, joystick and reset model
  // ------------------------------
  always @(posedge pclk or negedge pll_lckd) begin : model
    int   hi;
    int   oi;
    logic make;
    if (!pll_lckd) begin
      held_m    <= '0;
      opt_m     <= '0;
      rst_key_m <= 1'b0;
      mr_m      <= 1'b0;
      sel_m     <= 1'b0;
      cap_a_m   <= '1;
      cap_b_m   <= '1;
      core_m    <= 1'b1;
      reboot_m  <= 1'b0;
      lock_cnt  <= 0;
    end else begin
      hi   = held_bit_of(ev_d[2][7:0], ev_d[2][9]);
      oi   = option_bit_of(ev_d[2][7:0]);
      make = ~ev_d[2][8];
      mr_m <= 1'b0;
      if (ev_v[2]) begin
        if (hi >= 0) held_m[hi] <= make;
        if (oi >= 0 && make) opt_m[oi] <= ~opt_m[oi];
        if (ev_d[2][7:0] == `KEY_F12) rst_key_m <= make;
        if (ev_d[2][7:0] == `KEY_BKSP && make && held_m[4] && held_m[5]) begin
          mr_m <= 1'b1;
        end
      end
      sel_m <= ~sel_m;
      if (!sel_m) begin
        cap_a_m <= merge_player_a(jjoy, joystick, held_m);
      end else begin
        cap_b_m <= jjoy;
      end
      if (lock_cnt < 256) lock_cnt <= lock_cnt + 1;
      core_m   <= (lock_cnt < 255) || rst_key_m || !test_n;
      reboot_m <= mr_m || !service_n;
    end
  end

  always @(negedge pclk) begin
    if (armed) begin
      compare_value("joy_select", sel_m, joy_select);
      compare_value("joy_a", cap_a_m[5:0], joy_a);
      compare_value("joy_b", cap_b_m[5:0], joy_b);
      compare_value("player", {cap_b_m[7], cap_a_m[7]}, player);
      compare_value("scan_sw", {opt_m, held_m}, scan_sw);
      compare_value("led", opt_m[1], led);
      compare_value("core_reset", core_m, core_reset);
      compare_value("reboot", reboot_m, reboot);
    end
  end

endmodule

// ==== tests/tb_arcade_ctrl.sv ====
/*
 * Arcade control testbench
 * Seeded random keyboard, joystick and reset stimulus around the top level
 */
`include "arcade_config.svh"

module tb_arcade_ctrl;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int PS2_HALF = 20;

  logic                pclk;
  logic                pll_lckd;
  logic                ps2_clk;
  logic                ps2_data;
  logic [5:0]          joystick;
  input_pkg::joy_vec_t jjoy;
  logic                test_n;
  logic                service_n;
  logic                joy_select;
  logic [5:0]          joy_a;
  logic [5:0]          joy_b;
  logic [1:0]          player;
  input_pkg::scan_sw_t scan_sw;
  logic                led;
  logic                core_reset;
  logic                reboot;
  int                  errors;
  int                  checks;
  int                  assert_fails;
  integer              seed;
  logic                joy_run;
  int                  k;
  logic [7:0]          game_keys [8];
  logic [7:0]          opt_keys [4];

  arcade_ctrl_top arcade_ctrl_top_inst (
    .pclk       (pclk),
    .pll_lckd   (pll_lckd),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .joystick   (joystick),
    .jjoy       (jjoy),
    .test_n     (test_n),
    .service_n  (service_n),
    .joy_select (joy_select),
    .joy_a      (joy_a),
    .joy_b      (joy_b),
    .player     (player),
    .scan_sw    (scan_sw),
    .led        (led),
    .core_reset (core_reset),
    .reboot     (reboot)
  );

  arcade_ctrl_checker arcade_ctrl_checker_inst (
    .pclk       (pclk),
    .pll_lckd   (pll_lckd),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .joystick   (joystick),
    .jjoy       (jjoy),
    .test_n     (test_n),
    .service_n  (service_n),
    .joy_select (joy_select),
    .joy_a      (joy_a),
    .joy_b      (joy_b),
    .player     (player),
    .scan_sw    (scan_sw),
    .led        (led),
    .core_reset (core_reset),
    .reboot     (reboot),
    .errors     (errors),
    .checks     (checks)
  );

  initial pclk = 1'b0;
  always #5 pclk = ~pclk;

  // Fresh connector and board joystick values every cycle
  always @(negedge pclk) begin
    if (joy_run) begin
      joystick <= $random(seed);
      jjoy     <= $random(seed);
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("** FAIL **");
    $finish;
  endtask

  task automatic await_level(input string name, input logic level, input int limit);
    int   n;
    logic v;
    n = 0;
    v = (name == "reboot") ? reboot : core_reset;
    while (v !== level && n < limit) begin
      @(negedge pclk);
      v = (name == "reboot") ? reboot : core_reset;
      n++;
    end
    if (v !== level) begin
      abort_run($sformatf("timeout: %s never reached %b", name, level));
    end
  endtask

  // One 11-bit frame, LSB first, odd parity
  task automatic send_byte(input logic [7:0] b, input logic bad_parity,
                           input logic bad_stop);
    logic [10:0] frame;
    frame = {~bad_stop, (~^b) ^ bad_parity, b, 1'b0};
    @(negedge pclk);
    for (int i = 0; i < 11; i++) begin
      ps2_data = frame[i];
      repeat (PS2_HALF) @(negedge pclk);
      ps2_clk = 1'b0;
      repeat (PS2_HALF) @(negedge pclk);
      ps2_clk = 1'b1;
    end
    ps2_data = 1'b1;
    repeat (PS2_HALF) @(negedge pclk);
  endtask

  task automatic send_key(input logic [7:0] code, input logic ext, input logic brk);
    if (ext) send_byte(8'hE0, 1'b0, 1'b0);
    if (brk) send_byte(8'hF0, 1'b0, 1'b0);
    send_byte(code, 1'b0, 1'b0);
  endtask

  initial begin
    seed      = 32'h5ce;
    pll_lckd  = 1'b0;
    ps2_clk   = 1'b1;
    ps2_data  = 1'b1;
    joystick  = '1;
    jjoy      = '1;
    test_n    = 1'b1;
    service_n = 1'b1;
    joy_run   = 1'b0;
    game_keys = '{`KEY_UP, `KEY_DOWN, `KEY_LEFT, `KEY_RIGHT,
                  `KEY_CTRL, `KEY_ALT, `KEY_START1, `KEY_START2};
    opt_keys  = '{`KEY_F1, `KEY_F2, `KEY_F3, `KEY_F4};

    repeat (16) @(negedge pclk);
    pll_lckd = 1'b1;
    joy_run  = 1'b1;
    await_level("core_reset", 1'b0, 300);

    // ------------------------------
    // Held keys, arrows behind E0
    for (int i = 0; i < 40; i++) begin
      k = $unsigned($random(seed)) % 8;
      send_key(game_keys[k], k < 4, $random(seed) & 1);
    end

    // Option toggles
    for (int i = 0; i < 16; i++) begin
      k = $unsigned($random(seed)) % 4;
      send_key(opt_keys[k], 1'b0, $random(seed) & 1);
    end

    // Broken parity or stop bit, then one good frame
    for (int i = 0; i < 6; i++) begin
      k = $unsigned($random(seed)) % 4;
      send_byte(opt_keys[k], i % 2 == 0, i % 2 == 1);
    end
    send_key(`KEY_F2, 1'b0, 1'b0);

    for (int i = 0; i < 8; i++) begin
      send_key(game_keys[i], i < 4, 1'b1);
    end

    // ------------------------------
    // Reset and reboot requests
    send_key(`KEY_F12, 1'b0, 1'b0);
    await_level("core_reset", 1'b1, 10);
    send_key(`KEY_F12, 1'b0, 1'b1);
    await_level("core_reset", 1'b0, 10);

    test_n = 1'b0;
    await_level("core_reset", 1'b1, 4);
    repeat (3) @(negedge pclk);
    test_n = 1'b1;
    await_level("core_reset", 1'b0, 4);

    send_key(`KEY_CTRL, 1'b0, 1'b0);
    send_key(`KEY_ALT, 1'b0, 1'b0);
    fork
      send_key(`KEY_BKSP, 1'b0, 1'b0);
      await_level("reboot", 1'b1, 1000);
    join
    send_key(`KEY_BKSP, 1'b0, 1'b1);
    send_key(`KEY_ALT, 1'b0, 1'b1);
    send_key(`KEY_CTRL, 1'b0, 1'b1);

    service_n = 1'b0;
    @(negedge pclk);
    service_n = 1'b1;
    await_level("reboot", 1'b1, 4);

    joy_run = 1'b0;
    repeat (10) @(negedge pclk);
    assert_fails = arcade_ctrl_top_inst.joy_splitter_inst.joy_assert_inst.fails +
                   arcade_ctrl_top_inst.reset_sequencer_inst.reset_assert_inst.fails;
    $display("done: %0d checks, %0d errors, %0d assertion failures", checks, errors,
             assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+hdl
hdl/input_pkg.sv
hdl/ctrl_pkg.sv
hdl/key_event_if.sv
hdl/ps2_receiver.sv
hdl/key_mapper.sv
hdl/joy_splitter.sv
hdl/reset_sequencer.sv
hdl/arcade_ctrl_top.sv
tests/arcade_ctrl_assert.sv
tests/arcade_ctrl_checker.sv
tests/tb_arcade_ctrl.sv

// ==== Bender.yml ====
package:
  name: arcade_ctrl

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/input_pkg.sv
      - hdl/ctrl_pkg.sv
      - hdl/key_event_if.sv
      - hdl/ps2_receiver.sv
      - hdl/key_mapper.sv
      - hdl/joy_splitter.sv
      - hdl/reset_sequencer.sv
      - hdl/arcade_ctrl_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/arcade_ctrl_assert.sv
      - tests/arcade_ctrl_checker.sv
      - tests/tb_arcade_ctrl.sv
